// ==== lane_collect.f ====
+incdir+verilog
verilog/lc_bus_pkg.sv
verilog/lc_op_pkg.sv
verilog/wb_arbiter.sv
verilog/scratchpad.sv
verilog/operand_fetch.sv
verilog/lane_select.sv
verilog/result_writer.sv
verilog/lane_collect.sv
sim/tb_lane_collect.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the lane_collect testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir build.log "$LOG"

verilator --binary --timing --assert \
	--top-module tb_lane_collect \
	-f lane_collect.f \
	-o tb_lane_collect \
	> build.log 2>&1 \
	&& ./obj_dir/tb_lane_collect > "$LOG" 2>&1 \
	|| echo "TESTBENCH FAILED: build or simulator error" >> "$LOG"

cat build.log "$LOG"
grep -q "TESTBENCH FAILED" "$LOG" && exit 1 || exit 0

// ==== sim/tb_lane_collect.sv ====
`timescale 1ns/1ps
`include "lc_macros.svh"

module tb_lane_collect;

	localparam int AW         = `LC_ADDR_W;
	localparam int DW         = `LC_DATA_W;
	localparam int NL         = `LC_LANES;
	localparam int RST_CYCLES = 16;
	localparam int N_CMDS     = 23;  // commands in tests 2 to 6
	localparam int N_HOST_OPS = 300;
	localparam int MAX_CYCLES = N_CMDS * 200 + N_HOST_OPS * 5 + RST_CYCLES;

	logic                clk = 1'b0;
	logic                i_rst;
	lc_bus_pkg::wb_req_t host_req;
	lc_bus_pkg::wb_rsp_t host_rsp;
	logic                cmd_valid;
	lc_op_pkg::cmd_t     cmd;
	logic                cmd_ready;
	logic                done;
	lc_op_pkg::done_t    done_info;

	logic [DW-1:0]    model [`LC_DEPTH]; // expected scratchpad contents
	lc_op_pkg::done_t exp_done [N_CMDS];
	int               issued      = 0;
	int               done_count  = 0;
	int               checks      = 0;
	int               errors      = 0;
	int               done_checks = 0;
	int               done_errors = 0;
	int               cycles      = 0;
	int               t_checks    = 0;
	int               t_errors    = 0;

	lane_collect i_lane_collect
	(
		.clk         (clk),
		.i_rst       (i_rst),
		.i_host_req  (host_req),
		.o_host_rsp  (host_rsp),
		.i_cmd_valid (cmd_valid),
		.i_cmd       (cmd),
		.o_cmd_ready (cmd_ready),
		.o_done      (done),
		.o_done_info (done_info)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > MAX_CYCLES)
		begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	function automatic lc_op_pkg::done_t expect_done(input lc_op_pkg::cmd_t c);
		lc_op_pkg::done_t r;
		int               hits;
		int               lane;
		logic [DW-1:0]    word;
		hits = 0;
		lane = 0;
		for (int i = 0; i < NL; i++)
		begin
			if (c.sel[i])
			begin
				hits++;
				lane = i;
			end
		end
		word = model[c.src_addr + AW'(lane)]; // address wraps
		if (c.opcode == lc_op_pkg::OP_SCALE)
			word = word * c.scalar;
		else
			word = word + c.scalar;
		r.ok         = (hits == 1);
		r.lane_valid = r.ok && c.lane_mask[lane];
		r.value      = r.lane_valid ? word : '0;
		return r;
	endfunction

	function automatic void record_cmd(input lc_op_pkg::cmd_t c);
		exp_done[issued]  = expect_done(c);
		model[c.dst_addr] = exp_done[issued].value;
		issued++;
	endfunction

	function automatic lc_op_pkg::cmd_t make_cmd(input lc_op_pkg::opcode_e op,
		input logic [AW-1:0] src, input logic [AW-1:0] dst,
		input logic [NL-1:0] mask, input logic [NL-1:0] sel);
		lc_op_pkg::cmd_t c;
		c.opcode    = op;
		c.src_addr  = src;
		c.dst_addr  = dst;
		c.scalar    = $urandom;
		c.lane_mask = mask;
		c.sel       = sel;
		return c;
	endfunction

	task automatic check_done(input lc_op_pkg::done_t got, input lc_op_pkg::done_t exp);
		done_checks++;
		if (got !== exp)
		begin
			done_errors++;
			$display("** Error at %0d ns: done %0b %0b %h, expected %0b %0b %h (ok valid value)",
				$time, got.ok, got.lane_valid, got.value, exp.ok, exp.lane_valid, exp.value);
		end
	endtask

	task automatic check_word(input logic [DW-1:0] got, input logic [DW-1:0] exp,
		input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// compares every done pulse against the next recorded command
	always @(negedge clk)
	begin
		if (!i_rst && done)
		begin
			if (done_count >= issued)
			begin
				done_errors++;
				$display("done pulse at %0d ns with no command outstanding", $time);
			end
			else
				check_done(done_info, exp_done[done_count]);
			done_count++;
		end
	end

	task automatic host_access(input logic we, input logic [AW-1:0] adr,
		input logic [DW-1:0] wdata, output logic [DW-1:0] rdata);
		@(negedge clk);
		host_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
		do
			@(negedge clk);
		while (!host_rsp.ack);
		rdata = host_rsp.dat_r;
		@(negedge clk); // hold through the ack cycle
		host_req = '0;
	endtask

	task automatic host_write(input logic [AW-1:0] adr, input logic [DW-1:0] data);
		logic [DW-1:0] unused;
		host_access(1'b1, adr, data, unused);
		model[adr] = data;
	endtask

	task automatic host_read_check(input logic [AW-1:0] adr, input string what);
		logic [DW-1:0] data;
		host_access(1'b0, adr, '0, data);
		check_word(data, model[adr], what);
	endtask

	task automatic load_block(input logic [AW-1:0] src);
		for (int i = 0; i < NL; i++)
			host_write(src + AW'(i), $urandom);
	endtask

	task automatic issue_cmd(input lc_op_pkg::cmd_t c);
		record_cmd(c);
		@(negedge clk);
		while (!cmd_ready)
			@(negedge clk);
		cmd_valid = 1'b1;
		cmd       = c;
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	task automatic wait_all_done();
		while (done_count < issued)
			@(negedge clk);
	endtask

	task automatic run_one(input lc_op_pkg::opcode_e op, input logic [AW-1:0] src,
		input logic [AW-1:0] dst, input logic [NL-1:0] mask, input logic [NL-1:0] sel);
		load_block(src);
		host_write(dst, $urandom | 32'h1); // nonzero so a zero store shows
		issue_cmd(make_cmd(op, src, dst, mask, sel));
		wait_all_done();
		host_read_check(dst, "stored word");
	endtask

	task automatic start_test();
		t_checks = checks + done_checks;
		t_errors = errors + done_errors;
	endtask

	task automatic report_test(input int num, input string name);
		$display("test %0d %s: %0d checks, %0d errors", num, name,
			checks + done_checks - t_checks, errors + done_errors - t_errors);
	endtask

	initial
	begin
		logic [AW-1:0]   addrs [32];
		logic [NL-1:0]   mask;
		lc_op_pkg::cmd_t c_first;
		lc_op_pkg::cmd_t c_second;
		logic            seen;
		int unsigned     seed_val;
		seed_val  = $urandom(32'h200614f0);
		i_rst     = 1'b1;
		host_req  = '0;
		cmd_valid = 1'b0;
		cmd       = '0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		i_rst = 1'b0;

		start_test();
		check_flag(cmd_ready, 1'b1, "cmd_ready after reset");
		check_flag(done, 1'b0, "done after reset");
		check_flag(host_rsp.ack, 1'b0, "host ack after reset");
		for (int i = 0; i < 32; i++)
		begin
			addrs[i] = AW'($urandom);
			host_write(addrs[i], $urandom);
		end
		for (int i = 0; i < 32; i++)
			host_read_check(addrs[i], "host readback");
		report_test(1, "memory path");

		start_test();
		for (int op = 0; op < 2; op++)
		begin
			for (int lane = 0; lane < NL; lane++)
			begin
				run_one(lc_op_pkg::opcode_e'(op), 8'h10, AW'(8'h40 + lane), '1,
					NL'(1 << lane));
			end
		end
		report_test(2, "scale and offset");

		start_test();
		mask = NL'($urandom) & ~NL'(1 << 3);
		run_one(lc_op_pkg::opcode_e'($urandom_range(1, 0)), 8'h18, 8'h50, mask, 8'h08);
		mask = NL'($urandom) & ~NL'(1 << 6);
		run_one(lc_op_pkg::opcode_e'($urandom_range(1, 0)), 8'h18, 8'h51, mask, 8'h40);
		report_test(3, "masked lane");

		start_test();
		run_one(lc_op_pkg::opcode_e'($urandom_range(1, 0)), 8'h28, 8'h52, '1, 8'h00);
		run_one(lc_op_pkg::opcode_e'($urandom_range(1, 0)), 8'h30, 8'h53, '1, 8'h24);
		report_test(4, "bad select");

		start_test();
		load_block(8'h38);
		issue_cmd(make_cmd(lc_op_pkg::OP_SCALE, 8'h38, 8'h54, '1, 8'h20));
		for (int k = 0; k < 4; k++)
			host_write(AW'(8'hC0 + k), $urandom); // fetcher holds the bus here
		for (int k = 0; k < 4; k++)
			host_read_check(AW'(8'hC0 + k), "contention readback");
		wait_all_done();
		host_read_check(8'h54, "stored word");
		report_test(5, "contention");

		start_test();
		load_block(8'h60);
		load_block(8'h70);
		c_first  = make_cmd(lc_op_pkg::OP_OFFSET, 8'h60, 8'h58, '1, 8'h02);
		c_second = make_cmd(lc_op_pkg::OP_SCALE, 8'h70, 8'h59, '1, 8'h80);
		issue_cmd(c_first);
		record_cmd(c_second);
		cmd_valid = 1'b1; // second command waits on ready
		cmd       = c_second;
		seen      = 1'b0;
		while (!seen)
		begin
			@(negedge clk);
			check_flag(cmd_ready, 1'b0, "cmd_ready while busy");
			seen = done;
		end
		@(negedge clk);
		check_flag(cmd_ready, 1'b1, "cmd_ready after done");
		@(negedge clk);
		cmd_valid = 1'b0;
		check_flag(cmd_ready, 1'b0, "cmd_ready after second accept");
		wait_all_done();
		host_read_check(8'h58, "first stored word");
		host_read_check(8'h59, "second stored word");
		report_test(6, "readiness");

		repeat (4) @(negedge clk);
		$display("summary: 6 tests, %0d checks, %0d errors", checks + done_checks,
			errors + done_errors);
		if (errors + done_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== verilog/lane_collect.sv ====
`timescale 1ns/1ps
`include "lc_macros.svh"

module lane_collect
(
	input  logic                clk,
	input  logic                i_rst,
	input  lc_bus_pkg::wb_req_t i_host_req,
	output lc_bus_pkg::wb_rsp_t o_host_rsp,
	input  logic                i_cmd_valid,
	input  lc_op_pkg::cmd_t     i_cmd,
	output logic                o_cmd_ready,
	output logic                o_done,
	output lc_op_pkg::done_t    o_done_info
);

	lc_bus_pkg::wb_req_t                  fetch_req;
	lc_bus_pkg::wb_rsp_t                  fetch_rsp;
	lc_bus_pkg::wb_req_t                  writer_req;
	lc_bus_pkg::wb_rsp_t                  writer_rsp;
	lc_bus_pkg::wb_req_t                  mem_req;
	lc_bus_pkg::wb_rsp_t                  mem_rsp;

	logic [`LC_LANES-1:0][`LC_DATA_W-1:0] lane_data;
	logic [`LC_LANES-1:0]                 lane_valid;
	logic [`LC_LANES-1:0]                 sel;
	logic                                 en;
	logic [`LC_ADDR_W-1:0]                dst_addr;
	logic                                 sel_strobe;
	logic                                 sel_valid;
	logic [`LC_DATA_W-1:0]                sel_data;

	wb_arbiter u_arbiter
	(
		.clk          (clk),
		.i_rst        (i_rst),
		.i_req_host   (i_host_req),
		.i_req_writer (writer_req),
		.i_req_fetch  (fetch_req),
		.o_rsp_host   (o_host_rsp),
		.o_rsp_writer (writer_rsp),
		.o_rsp_fetch  (fetch_rsp),
		.o_mem_req    (mem_req),
		.i_mem_rsp    (mem_rsp)
	);

	scratchpad u_scratchpad
	(
		.clk   (clk),
		.i_rst (i_rst),
		.i_req (mem_req),
		.o_rsp (mem_rsp)
	);

	operand_fetch u_fetch
	(
		.clk          (clk),
		.i_rst        (i_rst),
		.i_cmd_valid  (i_cmd_valid),
		.i_cmd        (i_cmd),
		.o_cmd_ready  (o_cmd_ready),
		.o_bus_req    (fetch_req),
		.i_bus_rsp    (fetch_rsp),
		.o_lane_data  (lane_data),
		.o_lane_valid (lane_valid),
		.o_sel        (sel),
		.o_en         (en),
		.o_dst_addr   (dst_addr),
		.i_done       (o_done)
	);

	lane_select u_select
	(
		.clk          (clk),
		.i_rst        (i_rst),
		.i_en         (en),
		.i_sel        (sel),
		.i_lane_data  (lane_data),
		.i_lane_valid (lane_valid),
		.o_strobe     (sel_strobe),
		.o_valid      (sel_valid),
		.o_data       (sel_data)
	);

	result_writer u_writer
	(
		.clk         (clk),
		.i_rst       (i_rst),
		.i_strobe    (sel_strobe),
		.i_valid     (sel_valid),
		.i_data      (sel_data),
		.i_sel       (sel),
		.i_dst_addr  (dst_addr),
		.o_bus_req   (writer_req),
		.i_bus_rsp   (writer_rsp),
		.o_done      (o_done),
		.o_done_info (o_done_info)
	);

endmodule

// ==== verilog/result_writer.sv ====
`timescale 1ns/1ps
`include "lc_macros.svh"

module result_writer
(
	input  logic                   clk,
	input  logic                   i_rst,
	input  logic                   i_strobe,
	input  logic                   i_valid,
	input  logic [`LC_DATA_W-1:0]  i_data,
	input  logic [`LC_LANES-1:0]   i_sel,
	input  logic [`LC_ADDR_W-1:0]  i_dst_addr,
	output lc_bus_pkg::wb_req_t    o_bus_req,
	input  lc_bus_pkg::wb_rsp_t    i_bus_rsp,
	output logic                   o_done,
	output lc_op_pkg::done_t       o_done_info
);

	logic                  busy;
	logic                  valid_q;
	logic [`LC_DATA_W-1:0] data_q;
	logic                  sel_onehot;
	lc_op_pkg::done_t      info_q;

	assign sel_onehot = (i_sel != '0) && ((i_sel & (i_sel - 1'b1)) == '0);

	always_ff @(posedge clk)
	begin
		if (i_rst)
		begin
			busy   <= 1'b0;
			o_done <= 1'b0;
		end
		else
		begin
			o_done <= busy && i_bus_rsp.ack;
			if (i_strobe)
				busy <= 1'b1;
			else if (i_bus_rsp.ack)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_strobe)
		begin
			data_q  <= i_data;
			valid_q <= i_valid;
		end
		if (busy && i_bus_rsp.ack)
			info_q <= '{ok: sel_onehot, lane_valid: valid_q, value: data_q};
	end

	always_comb
	begin
		o_bus_req = '0;
		if (busy)
		begin
			o_bus_req.cyc   = 1'b1;
			o_bus_req.stb   = 1'b1;
			o_bus_req.we    = 1'b1;
			o_bus_req.adr   = i_dst_addr;
			o_bus_req.dat_w = data_q;
		end
	end

	assign o_done_info = info_q;

	// fetcher must hold off until done has been seen
	a_one_write: assert property (@(posedge clk) disable iff (i_rst)
		i_strobe |-> !busy && !o_done);

endmodule

// ==== verilog/lane_select.sv ====
`timescale 1ns/1ps
`include "lc_macros.svh"

module lane_select
(
	input  logic                                  clk,
	input  logic                                  i_rst,
	input  logic                                  i_en,
	input  logic [`LC_LANES-1:0]                  i_sel,
	input  logic [`LC_LANES-1:0][`LC_DATA_W-1:0]  i_lane_data,
	input  logic [`LC_LANES-1:0]                  i_lane_valid,
	output logic                                  o_strobe,
	output logic                                  o_valid,
	output logic [`LC_DATA_W-1:0]                 o_data
);

	logic [`LC_DATA_W-1:0] pick_data;
	logic                  pick_valid;

	// anything not exactly one-hot falls to default
	always_comb
	begin
		pick_data  = '0;
		pick_valid = 1'b0;
		case (i_sel)
			8'b0000_0001:
			begin
				pick_data  = i_lane_data[0];
				pick_valid = i_lane_valid[0];
			end
			8'b0000_0010:
			begin
				pick_data  = i_lane_data[1];
				pick_valid = i_lane_valid[1];
			end
			8'b0000_0100:
			begin
				pick_data  = i_lane_data[2];
				pick_valid = i_lane_valid[2];
			end
			8'b0000_1000:
			begin
				pick_data  = i_lane_data[3];
				pick_valid = i_lane_valid[3];
			end
			8'b0001_0000:
			begin
				pick_data  = i_lane_data[4];
				pick_valid = i_lane_valid[4];
			end
			8'b0010_0000:
			begin
				pick_data  = i_lane_data[5];
				pick_valid = i_lane_valid[5];
			end
			8'b0100_0000:
			begin
				pick_data  = i_lane_data[6];
				pick_valid = i_lane_valid[6];
			end
			8'b1000_0000:
			begin
				pick_data  = i_lane_data[7];
				pick_valid = i_lane_valid[7];
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (i_rst || !i_en)
		begin
			o_strobe <= 1'b0;
			o_valid  <= 1'b0;
			o_data   <= '0;
		end
		else
		begin
			o_strobe <= 1'b1;
			o_valid  <= pick_valid;
			o_data   <= pick_valid ? pick_data : '0; // invalid lane reads as zero
		end
	end

endmodule

// ==== verilog/operand_fetch.sv ====
`timescale 1ns/1ps
`include "lc_macros.svh"

module operand_fetch
(
	input  logic                                   clk,
	input  logic                                   i_rst,
	input  logic                                   i_cmd_valid,
	input  lc_op_pkg::cmd_t                        i_cmd,
	output logic                                   o_cmd_ready,
	output lc_bus_pkg::wb_req_t                    o_bus_req,
	input  lc_bus_pkg::wb_rsp_t                    i_bus_rsp,
	output logic [`LC_LANES-1:0][`LC_DATA_W-1:0]   o_lane_data,
	output logic [`LC_LANES-1:0]                   o_lane_valid,
	output logic [`LC_LANES-1:0]                   o_sel,
	output logic                                   o_en,
	output logic [`LC_ADDR_W-1:0]                  o_dst_addr,
	input  logic                                   i_done
);

	localparam int IW = $clog2(`LC_LANES);
	localparam int AW = `LC_ADDR_W;

	lc_op_pkg::fetch_state_e               state;
	lc_op_pkg::cmd_t                       cmd_q;
	logic [IW-1:0]                         idx;
	logic [`LC_LANES-1:0][`LC_DATA_W-1:0]  lane_q;
	logic [`LC_DATA_W-1:0]                 op_result;
	logic                                  accept;
	logic                                  rd_done;

	assign accept  = i_cmd_valid && o_cmd_ready;
	assign rd_done = (state == lc_op_pkg::F_READ) && i_bus_rsp.ack;

	always_comb
	begin
		case (cmd_q.opcode)
			lc_op_pkg::OP_SCALE: op_result = i_bus_rsp.dat_r * cmd_q.scalar;
			default:             op_result = i_bus_rsp.dat_r + cmd_q.scalar;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (i_rst)
		begin
			state <= lc_op_pkg::F_IDLE;
			idx   <= '0;
		end
		else
		begin
			case (state)
				lc_op_pkg::F_IDLE:
					if (accept)
					begin
						state <= lc_op_pkg::F_READ;
						idx   <= '0;
					end
				lc_op_pkg::F_READ:
					if (i_bus_rsp.ack)
					begin
						idx <= idx + 1'b1;
						if (idx == IW'(`LC_LANES - 1))
							state <= lc_op_pkg::F_ISSUE;
					end
				lc_op_pkg::F_ISSUE:
					state <= lc_op_pkg::F_WAIT_DONE;
				default: // F_WAIT_DONE
					if (i_done)
						state <= lc_op_pkg::F_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			cmd_q <= i_cmd;
		if (rd_done)
			lane_q[idx] <= op_result;
	end

	// cyc held across all eight reads
	always_comb
	begin
		o_bus_req = '0;
		if (state == lc_op_pkg::F_READ)
		begin
			o_bus_req.cyc = 1'b1;
			o_bus_req.stb = 1'b1;
			o_bus_req.adr = cmd_q.src_addr + AW'(idx);
		end
	end

	assign o_cmd_ready  = (state == lc_op_pkg::F_IDLE);
	assign o_en         = (state == lc_op_pkg::F_ISSUE);
	assign o_lane_data  = lane_q;
	assign o_lane_valid = cmd_q.lane_mask;
	assign o_sel        = cmd_q.sel;
	assign o_dst_addr   = cmd_q.dst_addr;

endmodule

// ==== verilog/scratchpad.sv ====
`timescale 1ns/1ps
`include "lc_macros.svh"

module scratchpad
(
	input  logic                clk,
	input  logic                i_rst,
	input  lc_bus_pkg::wb_req_t i_req,
	output lc_bus_pkg::wb_rsp_t o_rsp
);

	logic [`LC_DATA_W-1:0] mem [`LC_DEPTH];
	logic [`LC_DATA_W-1:0] rdata;
	logic                  ack;
	logic                  access;

	// no new access in the ack cycle
	assign access = i_req.cyc && i_req.stb && !ack;

	always_ff @(posedge clk)
	begin
		if (i_rst)
			ack <= 1'b0;
		else
			ack <= access;
	end

	always_ff @(posedge clk)
	begin
		if (access)
		begin
			if (i_req.we)
				mem[i_req.adr] <= i_req.dat_w;
			rdata <= mem[i_req.adr]; // old word on a write
		end
	end

	assign o_rsp = '{ack: ack, dat_r: rdata};

	// strobe and request held through the ack
	a_ack_after_stb: assert property (@(posedge clk) disable iff (i_rst)
		o_rsp.ack |-> i_req.cyc && i_req.stb && $stable(i_req.adr) && $stable(i_req.we));

endmodule

// ==== verilog/wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter
(
	input  logic                clk,
	input  logic                i_rst,
	input  lc_bus_pkg::wb_req_t i_req_host,
	input  lc_bus_pkg::wb_req_t i_req_writer,
	input  lc_bus_pkg::wb_req_t i_req_fetch,
	output lc_bus_pkg::wb_rsp_t o_rsp_host,
	output lc_bus_pkg::wb_rsp_t o_rsp_writer,
	output lc_bus_pkg::wb_rsp_t o_rsp_fetch,
	output lc_bus_pkg::wb_req_t o_mem_req,
	input  lc_bus_pkg::wb_rsp_t i_mem_rsp
);

	lc_bus_pkg::master_e owner;
	lc_bus_pkg::master_e grant;

	always_comb
	begin
		grant = lc_bus_pkg::M_NONE;
		case (owner) // keep the bus while the owner holds cyc
			lc_bus_pkg::M_HOST:   if (i_req_host.cyc) grant = lc_bus_pkg::M_HOST;
			lc_bus_pkg::M_WRITER: if (i_req_writer.cyc) grant = lc_bus_pkg::M_WRITER;
			lc_bus_pkg::M_FETCH:  if (i_req_fetch.cyc) grant = lc_bus_pkg::M_FETCH;
			default: ;
		endcase
		if (grant == lc_bus_pkg::M_NONE)
		begin
			if (i_req_host.cyc)
				grant = lc_bus_pkg::M_HOST;
			else if (i_req_writer.cyc)
				grant = lc_bus_pkg::M_WRITER;
			else if (i_req_fetch.cyc)
				grant = lc_bus_pkg::M_FETCH;
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_rst)
			owner <= lc_bus_pkg::M_NONE;
		else
			owner <= grant;
	end

	always_comb
	begin
		case (grant)
			lc_bus_pkg::M_HOST:   o_mem_req = i_req_host;
			lc_bus_pkg::M_WRITER: o_mem_req = i_req_writer;
			lc_bus_pkg::M_FETCH:  o_mem_req = i_req_fetch;
			default:              o_mem_req = '0;
		endcase
	end

	// read data fans out and ack goes only to the owner
	assign o_rsp_host   = '{ack: i_mem_rsp.ack && (grant == lc_bus_pkg::M_HOST),
		dat_r: i_mem_rsp.dat_r};
	assign o_rsp_writer = '{ack: i_mem_rsp.ack && (grant == lc_bus_pkg::M_WRITER),
		dat_r: i_mem_rsp.dat_r};
	assign o_rsp_fetch  = '{ack: i_mem_rsp.ack && (grant == lc_bus_pkg::M_FETCH),
		dat_r: i_mem_rsp.dat_r};

	// an ack belongs to the master that owned the previous cycle and still does
	a_ack_to_owner: assert property (@(posedge clk) disable iff (i_rst)
		i_mem_rsp.ack |-> (grant == owner));

endmodule

// ==== verilog/lc_op_pkg.sv ====
`include "lc_macros.svh"

package lc_op_pkg;

	typedef enum logic
	{
		OP_SCALE  = 1'b0, // word * scalar keeping low bits
		OP_OFFSET = 1'b1  // word + scalar with wrap
	} opcode_e;

	typedef struct packed
	{
		opcode_e               opcode;
		logic [`LC_ADDR_W-1:0] src_addr;
		logic [`LC_ADDR_W-1:0] dst_addr;
		logic [`LC_DATA_W-1:0] scalar;
		logic [`LC_LANES-1:0]  lane_mask;
		logic [`LC_LANES-1:0]  sel;       // expected one-hot
	} cmd_t;

	typedef enum logic [1:0]
	{
		F_IDLE      = 2'd0,
		F_READ      = 2'd1,
		F_ISSUE     = 2'd2,
		F_WAIT_DONE = 2'd3
	} fetch_state_e;

	typedef struct packed
	{
		logic                  ok;         // sel was one-hot
		logic                  lane_valid;
		logic [`LC_DATA_W-1:0] value;
	} done_t;

endpackage

// ==== verilog/lc_bus_pkg.sv ====
`include "lc_macros.svh"

package lc_bus_pkg;

	// wishbone classic master side
	typedef struct packed
	{
		logic                  cyc;
		logic                  stb;
		logic                  we;
		logic [`LC_ADDR_W-1:0] adr;
		logic [`LC_DATA_W-1:0] dat_w;
	} wb_req_t;

	// slave side
	typedef struct packed
	{
		logic                  ack;
		logic [`LC_DATA_W-1:0] dat_r;
	} wb_rsp_t;

	// bus owners with M_NONE when idle
	typedef enum logic [1:0]
	{
		M_HOST   = 2'd0,
		M_WRITER = 2'd1,
		M_FETCH  = 2'd2,
		M_NONE   = 2'd3
	} master_e;

endpackage

// ==== verilog/lc_macros.svh ====
`ifndef LC_MACROS_SVH
`define LC_MACROS_SVH

// datapath word
`define LC_DATA_W 32

// scratchpad word address
`define LC_ADDR_W 8
`define LC_DEPTH  256

// selector decodes exactly eight one-hot patterns
`define LC_LANES  8

`endif
